// ==== rtl/cart_pkg.sv ====
`default_nettype none

package cart_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Bus widths

  typedef logic [23:0] snes_addr_t;      // Console address, bank + offset
  typedef logic [23:0] rom_addr_t;       // PSRAM byte address, bit 0 = lane
  typedef logic [22:0] rom_word_addr_t;  // PSRAM word address on the pins
  typedef logic [7:0]  byte_t;
  typedef logic [15:0] rom_word_t;

  ////////////////////////////////////////////////////////////////////////////
  // Control widths

  typedef logic [7:0]  strobe_hist_t;    // Newest sample in bit 0
  typedef logic [3:0]  mem_delay_t;
  typedef logic [17:0] dead_cnt_t;

  // ROM access FSM
  typedef enum logic [1:0] {
    st_idle,
    st_mcu_rd,
    st_mcu_wr,
    st_done
  } arb_state_t;

  ////////////////////////////////////////////////////////////////////////////
  // Defaults for the top level parameters

  localparam mem_delay_t DEFAULT_ROM_CYCLE_LEN = 4'd7;
  // About 1 ms of CLK2
  localparam dead_cnt_t  DEFAULT_DEAD_TIMEOUT  = 18'd88000;
  localparam rom_addr_t  DEFAULT_ROM_MASK      = 24'hFFFFFF;

endpackage

`default_nettype wire

// ==== rtl/snes_bus_sampler.sv ====
`timescale 1ns/100ps
`default_nettype none

module snes_bus_sampler #(
  parameter cart_pkg::dead_cnt_t dead_timeout = cart_pkg::DEFAULT_DEAD_TIMEOUT
) (
  input  logic CLK2,
  input  logic reset,
  input  logic snes_read_n,
  input  logic snes_cpu_clk,
  input  logic rom_hit,       // Current console address is in ROM
  output logic free_slot,
  output logic snes_dead,
  output logic wake
);

  cart_pkg::strobe_hist_t read_hist;
  cart_pkg::strobe_hist_t cpu_clk_hist;
  cart_pkg::dead_cnt_t    dead_cnt;

  logic read_start;
  logic cycle_start;
  logic cycle_end;
  logic free_strobe;

  ////////////////////////////////////////////////////////////////////////////
  // Strobe histories

  always_ff @(posedge CLK2) begin
    if (reset) begin
      read_hist    <= '1;
      cpu_clk_hist <= '1;
    end else begin
      read_hist    <= {read_hist[6:0], snes_read_n};
      cpu_clk_hist <= {cpu_clk_hist[6:0], snes_cpu_clk};
    end
  end

  // Bit 0 is skipped, so an edge shows two clocks after the pin
  assign read_start  = (read_hist[7:1] == 7'b1111110);
  assign cycle_end   = (cpu_clk_hist[4:1] == 4'b1110);
  assign cycle_start = (cpu_clk_hist[4:1] == 4'b0001);

  // Cycle start off the ROM window frees the following clock
  always_ff @(posedge CLK2) begin
    if (reset) begin
      free_strobe <= 1'b0;
    end else begin
      free_strobe <= cycle_start & ~rom_hit;
    end
  end

  // A console ROM read starting now takes the bus
  assign free_slot = (cycle_end | free_strobe) & ~(read_start & rom_hit);

  ////////////////////////////////////////////////////////////////////////////
  // Dead console watchdog

  always_ff @(posedge CLK2) begin
    if (reset) begin
      dead_cnt  <= '0;
      snes_dead <= 1'b1;
    end else begin
      if (cpu_clk_hist[1]) begin
        dead_cnt <= '0;
      end else if (!snes_dead) begin
        dead_cnt <= dead_cnt + cart_pkg::dead_cnt_t'(1);  // Stops once dead
      end

      if (cpu_clk_hist[1]) begin
        snes_dead <= 1'b0;
      end else if (dead_cnt > dead_timeout) begin
        snes_dead <= 1'b1;
      end
    end
  end

  assign wake = snes_dead & cpu_clk_hist[1];  // Clock back while still dead

endmodule

`default_nettype wire

// ==== rtl/rom_slot_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module rom_slot_arbiter #(
  parameter cart_pkg::mem_delay_t rom_cycle_len = cart_pkg::DEFAULT_ROM_CYCLE_LEN
) (
  input  logic                CLK2,
  input  logic                reset,
  input  logic                free_slot,
  input  logic                snes_dead,
  input  logic                wake,
  input  logic                mcu_req,
  input  logic                mcu_write,
  input  cart_pkg::rom_addr_t mcu_addr,
  input  cart_pkg::byte_t     mcu_wdata,
  input  cart_pkg::byte_t     rom_lane_byte,
  output logic                mcu_ack,
  output cart_pkg::byte_t     mcu_rdata,
  output logic                mcu_hit_rd,
  output logic                mcu_hit_wr,
  output cart_pkg::rom_addr_t mcu_rom_addr,
  output cart_pkg::byte_t     mcu_wdata_q
);

  cart_pkg::arb_state_t state;
  cart_pkg::mem_delay_t mem_delay;

  logic req_q;
  logic req_rise;
  logic pend;
  logic write_q;

  ////////////////////////////////////////////////////////////////////////////
  // MCU handshake front end

  assign req_rise = mcu_req & ~req_q;

  always_ff @(posedge CLK2) begin
    if (reset) begin
      req_q <= 1'b0;
    end else begin
      req_q <= mcu_req;
    end
  end

  // Request payload, held until the next request
  always_ff @(posedge CLK2) begin
    if (req_rise && !pend) begin
      mcu_rom_addr <= mcu_addr;
      mcu_wdata_q  <= mcu_wdata;
      write_q      <= mcu_write;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // ROM access FSM

  always_ff @(posedge CLK2) begin
    if (reset) begin
      state     <= cart_pkg::st_idle;
      mem_delay <= '0;
      pend      <= 1'b0;
      mcu_ack   <= 1'b0;
    end else begin
      if (req_rise && !pend) begin
        pend <= 1'b1;
      end
      if (mcu_ack && !mcu_req) begin
        mcu_ack <= 1'b0;                   // Fourth phase
      end

      if (wake) begin
        state <= cart_pkg::st_idle;        // Console back, redo the access
      end else begin
        case (state)
          cart_pkg::st_idle: begin
            if (pend && (free_slot || snes_dead)) begin
              state     <= write_q ? cart_pkg::st_mcu_wr : cart_pkg::st_mcu_rd;
              mem_delay <= rom_cycle_len;
            end
          end
          cart_pkg::st_mcu_rd, cart_pkg::st_mcu_wr: begin
            mem_delay <= mem_delay - cart_pkg::mem_delay_t'(1);
            if (mem_delay == '0) begin
              state <= cart_pkg::st_done;
            end
          end
          cart_pkg::st_done: begin
            state   <= cart_pkg::st_idle;
            pend    <= 1'b0;
            mcu_ack <= 1'b1;
          end
          default: state <= cart_pkg::st_idle;
        endcase
      end
    end
  end

  // Last sample of the read window wins
  always_ff @(posedge CLK2) begin
    if (state == cart_pkg::st_mcu_rd) begin
      mcu_rdata <= rom_lane_byte;
    end
  end

  assign mcu_hit_rd = (state == cart_pkg::st_mcu_rd);
  assign mcu_hit_wr = (state == cart_pkg::st_mcu_wr);

endmodule

`default_nettype wire

// ==== rtl/lorom_mapper.sv ====
`timescale 1ns/100ps
`default_nettype none

module lorom_mapper #(
  parameter cart_pkg::rom_addr_t rom_mask = cart_pkg::DEFAULT_ROM_MASK
) (
  input  cart_pkg::snes_addr_t snes_addr,
  output logic                 rom_hit,
  output cart_pkg::rom_addr_t  mapped_addr
);

  logic [7:0]          bank;
  logic                wram_bank;
  cart_pkg::rom_addr_t lorom_addr;

  assign bank = snes_addr[23:16];

  // Banks 7E and 7F are work RAM
  assign wram_bank = (bank[7:1] == 7'b0111111);

  // Upper half of each bank is ROM
  assign rom_hit = snes_addr[15] & ~wram_bank;

  ////////////////////////////////////////////////////////////////////////////
  // LoROM folding, 32 KiB per bank

  assign lorom_addr = {2'b00, bank[6:0], snes_addr[14:0]};

  assign mapped_addr = lorom_addr & rom_mask;  // Mirrors small images

endmodule

`default_nettype wire

// ==== rtl/rom_bus_mux.sv ====
`timescale 1ns/100ps
`default_nettype none

module rom_bus_mux (
  input  cart_pkg::rom_addr_t      mapped_addr,
  input  cart_pkg::rom_addr_t      mcu_rom_addr,
  input  logic                     mcu_hit_rd,
  input  logic                     mcu_hit_wr,
  input  logic                     rom_hit,
  input  logic                     snes_read_n,
  input  cart_pkg::byte_t          mcu_wdata_q,
  input  cart_pkg::rom_word_t      rom_dq_in,
  output cart_pkg::rom_word_addr_t rom_addr,
  output cart_pkg::rom_word_t      rom_dq_out,
  output logic                     rom_dq_oe,
  output logic                     rom_we_n,
  output logic                     rom_bhe_n,
  output logic                     rom_ble_n,
  output cart_pkg::byte_t          rom_lane_byte,
  output cart_pkg::byte_t          snes_data_out,
  output logic                     snes_data_oe
);

  cart_pkg::rom_addr_t sel_addr;
  logic                mcu_hit;
  logic                lane;           // 1 = odd byte, low lane

  ////////////////////////////////////////////////////////////////////////////
  // Address select

  assign mcu_hit  = mcu_hit_rd | mcu_hit_wr;
  assign sel_addr = mcu_hit ? mcu_rom_addr : mapped_addr;

  assign rom_addr = sel_addr[23:1];
  assign lane     = sel_addr[0];

  // Only the addressed lane is enabled
  assign rom_bhe_n = lane;
  assign rom_ble_n = ~lane;

  assign rom_lane_byte = lane ? rom_dq_in[7:0] : rom_dq_in[15:8];

  ////////////////////////////////////////////////////////////////////////////
  // PSRAM write side, MCU only

  always_comb begin
    if (lane) begin
      rom_dq_out = {8'h00, mcu_wdata_q};
    end else begin
      rom_dq_out = {mcu_wdata_q, 8'h00};
    end
  end

  assign rom_dq_oe = mcu_hit_wr;
  assign rom_we_n  = ~mcu_hit_wr;

  // Console side, ROM reads only
  assign snes_data_out = rom_lane_byte;
  assign snes_data_oe  = ~snes_read_n & rom_hit;

endmodule

`default_nettype wire

// ==== rtl/cart_main.sv ====
`timescale 1ns/100ps
`default_nettype none

module cart_main #(
  parameter cart_pkg::mem_delay_t rom_cycle_len = cart_pkg::DEFAULT_ROM_CYCLE_LEN,
  parameter cart_pkg::dead_cnt_t  dead_timeout  = cart_pkg::DEFAULT_DEAD_TIMEOUT,
  parameter cart_pkg::rom_addr_t  rom_mask      = cart_pkg::DEFAULT_ROM_MASK
) (
  input  logic                     CLK2,
  input  logic                     reset,
  // Console bus
  input  cart_pkg::snes_addr_t     snes_addr,
  input  logic                     snes_read_n,
  input  logic                     snes_write_n,
  input  logic                     snes_cpu_clk,
  output cart_pkg::byte_t          snes_data_out,
  output logic                     snes_data_oe,
  // PSRAM
  input  cart_pkg::rom_word_t      rom_dq_in,
  output cart_pkg::rom_word_addr_t rom_addr,
  output cart_pkg::rom_word_t      rom_dq_out,
  output logic                     rom_dq_oe,
  output logic                     rom_we_n,
  output logic                     rom_bhe_n,
  output logic                     rom_ble_n,
  // MCU
  input  logic                     mcu_req,
  input  logic                     mcu_write,
  input  cart_pkg::rom_addr_t      mcu_addr,
  input  cart_pkg::byte_t          mcu_wdata,
  output logic                     mcu_ack,
  output cart_pkg::byte_t          mcu_rdata
);

  logic                free_slot;
  logic                snes_dead;
  logic                wake;
  logic                rom_hit;
  logic                mcu_hit_rd;
  logic                mcu_hit_wr;
  cart_pkg::rom_addr_t mapped_addr;
  cart_pkg::rom_addr_t mcu_rom_addr;
  cart_pkg::byte_t     mcu_wdata_q;
  cart_pkg::byte_t     rom_lane_byte;

  ////////////////////////////////////////////////////////////////////////////
  // Sampler, arbiter, mux

  snes_bus_sampler #(
    .dead_timeout (dead_timeout)
  ) u_sampler (
    .CLK2         (CLK2),
    .reset        (reset),
    .snes_read_n  (snes_read_n),
    .snes_cpu_clk (snes_cpu_clk),
    .rom_hit      (rom_hit),
    .free_slot    (free_slot),
    .snes_dead    (snes_dead),
    .wake         (wake)
  );

  rom_slot_arbiter #(
    .rom_cycle_len (rom_cycle_len)
  ) u_arbiter (
    .CLK2          (CLK2),
    .reset         (reset),
    .free_slot     (free_slot),
    .snes_dead     (snes_dead),
    .wake          (wake),
    .mcu_req       (mcu_req),
    .mcu_write     (mcu_write),
    .mcu_addr      (mcu_addr),
    .mcu_wdata     (mcu_wdata),
    .rom_lane_byte (rom_lane_byte),
    .mcu_ack       (mcu_ack),
    .mcu_rdata     (mcu_rdata),
    .mcu_hit_rd    (mcu_hit_rd),
    .mcu_hit_wr    (mcu_hit_wr),
    .mcu_rom_addr  (mcu_rom_addr),
    .mcu_wdata_q   (mcu_wdata_q)
  );

  lorom_mapper #(
    .rom_mask    (rom_mask)
  ) u_mapper (
    .snes_addr   (snes_addr),
    .rom_hit     (rom_hit),
    .mapped_addr (mapped_addr)
  );

  rom_bus_mux u_mux (
    .mapped_addr   (mapped_addr),
    .mcu_rom_addr  (mcu_rom_addr),
    .mcu_hit_rd    (mcu_hit_rd),
    .mcu_hit_wr    (mcu_hit_wr),
    .rom_hit       (rom_hit),
    .snes_read_n   (snes_read_n),
    .mcu_wdata_q   (mcu_wdata_q),
    .rom_dq_in     (rom_dq_in),
    .rom_addr      (rom_addr),
    .rom_dq_out    (rom_dq_out),
    .rom_dq_oe     (rom_dq_oe),
    .rom_we_n      (rom_we_n),
    .rom_bhe_n     (rom_bhe_n),
    .rom_ble_n     (rom_ble_n),
    .rom_lane_byte (rom_lane_byte),
    .snes_data_out (snes_data_out),
    .snes_data_oe  (snes_data_oe)
  );

endmodule

`default_nettype wire

// ==== bench/clock_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module clock_gen #(
  parameter int half_period  = 2,
  parameter int reset_cycles = 8
) (
  output logic CLK2,
  output logic reset
);

  initial begin
    CLK2 = 1'b0;
    forever #(half_period) CLK2 = ~CLK2;
  end

  // Release lands 1 ns after an edge, like the other inputs
  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge CLK2);
    #1;
    reset = 1'b0;
  end

endmodule

`default_nettype wire

// ==== bench/cart_main_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module cart_main_tb;

  localparam int                  DEAD_TIMEOUT = 200;
  localparam cart_pkg::rom_addr_t ROM_MASK     = 24'h0FFFFF;
  localparam int                  ACK_TIMEOUT  = 100;

  logic                     CLK2;
  logic                     reset;
  cart_pkg::snes_addr_t     snes_addr;
  logic                     snes_read_n;
  logic                     snes_write_n;
  logic                     snes_cpu_clk;
  cart_pkg::byte_t          snes_data_out;
  logic                     snes_data_oe;
  cart_pkg::rom_word_t      rom_dq_in;
  cart_pkg::rom_word_addr_t rom_addr;
  cart_pkg::rom_word_t      rom_dq_out;
  logic                     rom_dq_oe;
  logic                     rom_we_n;
  logic                     rom_bhe_n;
  logic                     rom_ble_n;
  logic                     mcu_req;
  logic                     mcu_write;
  cart_pkg::rom_addr_t      mcu_addr;
  cart_pkg::byte_t          mcu_wdata;
  logic                     mcu_ack;
  cart_pkg::byte_t          mcu_rdata;

  cart_pkg::rom_word_t rom_mem [0:(1 << 19) - 1];  // 1 MiB PSRAM model
  logic                pl_en;
  logic [18:0]         pl_idx;
  cart_pkg::rom_word_t pl_word;

  logic        cpu_run;
  logic [3:0]  cpu_cnt   = 4'd0;
  logic        cpu_phase = 1'b0;
  logic [15:0] lfsr_state;
  int          err_count;
  int          test_count;
  int          failed_tests;
  cart_pkg::byte_t wbytes [4];

  clock_gen u_clock_gen (
    .CLK2  (CLK2),
    .reset (reset)
  );

  cart_main #(
    .dead_timeout  (DEAD_TIMEOUT),
    .rom_mask      (ROM_MASK)
  ) u_cart_main (
    .CLK2          (CLK2),
    .reset         (reset),
    .snes_addr     (snes_addr),
    .snes_read_n   (snes_read_n),
    .snes_write_n  (snes_write_n),
    .snes_cpu_clk  (snes_cpu_clk),
    .snes_data_out (snes_data_out),
    .snes_data_oe  (snes_data_oe),
    .rom_dq_in     (rom_dq_in),
    .rom_addr      (rom_addr),
    .rom_dq_out    (rom_dq_out),
    .rom_dq_oe     (rom_dq_oe),
    .rom_we_n      (rom_we_n),
    .rom_bhe_n     (rom_bhe_n),
    .rom_ble_n     (rom_ble_n),
    .mcu_req       (mcu_req),
    .mcu_write     (mcu_write),
    .mcu_addr      (mcu_addr),
    .mcu_wdata     (mcu_wdata),
    .mcu_ack       (mcu_ack),
    .mcu_rdata     (mcu_rdata)
  );

  ////////////////////////////////////////////////////////////////////////////
  // PSRAM model and console CPU clock

  assign rom_dq_in = rom_mem[rom_addr[18:0]];

  always @(posedge CLK2) begin
    if (pl_en) begin
      rom_mem[pl_idx] <= pl_word;                    // Bench preload
    end else if (!rom_we_n) begin
      if (!rom_bhe_n) begin
        rom_mem[rom_addr[18:0]][15:8] <= rom_dq_out[15:8];
      end
      if (!rom_ble_n) begin
        rom_mem[rom_addr[18:0]][7:0] <= rom_dq_out[7:0];
      end
    end
  end

  // 6 high, 6 low
  always @(posedge CLK2) begin
    #1;
    if (!cpu_run) begin
      cpu_cnt   <= 4'd0;
      cpu_phase <= 1'b0;
    end else if (cpu_cnt == 4'd5) begin
      cpu_cnt   <= 4'd0;
      cpu_phase <= ~cpu_phase;
    end else begin
      cpu_cnt <= cpu_cnt + 4'd1;
    end
  end

  assign snes_cpu_clk = cpu_phase;

  ////////////////////////////////////////////////////////////////////////////
  // Helpers

  task automatic step();
    @(posedge CLK2);
    #1;
  endtask

  // Galois taps 16,14,13,11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic draw_random_byte(output cart_pkg::byte_t b);
    b = '0;
    for (int i = 0; i < 8; i++) begin
      b = {lfsr_state[0], b[7:1]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  function automatic cart_pkg::rom_word_addr_t lorom_word(input cart_pkg::snes_addr_t a);
    logic [23:0] byte_addr;
    byte_addr = ({17'd0, a[22:16]} * 24'd32768 + {9'd0, a[14:0]}) & ROM_MASK;
    return byte_addr[23:1];
  endfunction

  function automatic cart_pkg::byte_t lane_of(input cart_pkg::rom_word_t w, input logic odd);
    return odd ? w[7:0] : w[15:8];                  // Even byte on the high lane
  endfunction

  task automatic compare_byte(input string name, input cart_pkg::byte_t exp,
                              input cart_pkg::byte_t act);
    if (exp !== act) begin
      $display("MISMATCH %s expected %h actual %h", name, exp, act);
      err_count = err_count + 1;
    end
  endtask

  task automatic compare_rom_addr(input string name, input cart_pkg::rom_word_addr_t exp,
                                  input cart_pkg::rom_word_addr_t act);
    if (exp !== act) begin
      $display("MISMATCH %s expected %h actual %h", name, exp, act);
      err_count = err_count + 1;
    end
  endtask

  task automatic compare_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("MISMATCH %s expected %b actual %b", name, exp, act);
      err_count = err_count + 1;
    end
  endtask

  task automatic report_test(input string name, input int errs_at_start);
    test_count = test_count + 1;
    if (err_count == errs_at_start) begin
      $display("PASS %s", name);
    end else begin
      failed_tests = failed_tests + 1;
      $display("FAIL %s", name);
    end
  endtask

  task automatic preload_word(input logic [18:0] idx, input cart_pkg::rom_word_t word);
    pl_idx  = idx;
    pl_word = word;
    pl_en   = 1'b1;
    step();
    pl_en   = 1'b0;
  endtask

  // One four-phase MCU transfer
  task automatic mcu_access(input string name, input logic write,
                            input cart_pkg::rom_addr_t addr, input cart_pkg::byte_t wdata,
                            output cart_pkg::byte_t rdata);
    int n;
    mcu_write = write;
    mcu_addr  = addr;
    mcu_wdata = wdata;
    mcu_req   = 1'b1;
    n = 0;
    while (!mcu_ack && n < ACK_TIMEOUT) begin
      step();
      n = n + 1;
      // Data bus is driven exactly while the write strobe is low
      compare_bit({name, " rom_dq_oe"}, ~rom_we_n, rom_dq_oe);
      if (!write) begin
        compare_bit({name, " rom_we_n"}, 1'b1, rom_we_n);
      end
    end
    if (!mcu_ack) begin
      $display("%s: the arbiter never raised ack within %0d cycles", name, ACK_TIMEOUT);
      err_count = err_count + 1;
    end
    rdata   = mcu_rdata;
    mcu_req = 1'b0;
    n = 0;
    while (mcu_ack && n < ACK_TIMEOUT) begin
      step();
      n = n + 1;
    end
    if (mcu_ack) begin
      $display("%s: ack stayed high after the request was dropped", name);
      err_count = err_count + 1;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests

  task automatic test_reset_state();
    int errs_at_start;
    errs_at_start = err_count;
    compare_bit("reset_state mcu_ack", 1'b0, mcu_ack);
    compare_bit("reset_state rom_we_n", 1'b1, rom_we_n);
    compare_bit("reset_state rom_dq_oe", 1'b0, rom_dq_oe);
    compare_bit("reset_state snes_data_oe", 1'b0, snes_data_oe);
    report_test("reset_state", errs_at_start);
  endtask

  task automatic test_dead_writes();
    int                  errs_at_start;
    cart_pkg::rom_addr_t addr;
    cart_pkg::byte_t     unused;
    errs_at_start = err_count;
    repeat (DEAD_TIMEOUT + 16) step();              // CPU clock stays low
    for (int i = 0; i < 4; i++) begin
      addr = 24'h001230 + cart_pkg::rom_addr_t'(i);
      draw_random_byte(wbytes[i]);
      mcu_access("dead_writes", 1'b1, addr, wbytes[i], unused);
      compare_byte("dead_writes model", wbytes[i], lane_of(rom_mem[addr[19:1]], addr[0]));
    end
    report_test("dead_writes", errs_at_start);
  endtask

  task automatic test_mcu_readback();
    int                  errs_at_start;
    cart_pkg::rom_addr_t addr;
    cart_pkg::byte_t     rdata;
    errs_at_start = err_count;
    for (int i = 0; i < 4; i++) begin
      addr = 24'h001230 + cart_pkg::rom_addr_t'(i);
      mcu_access("mcu_readback", 1'b0, addr, 8'h00, rdata);
      compare_byte("mcu_readback", wbytes[i], rdata);
    end
    report_test("mcu_readback", errs_at_start);
  endtask

  task automatic test_console_read();
    int                       errs_at_start;
    cart_pkg::snes_addr_t     addrs [4];
    cart_pkg::rom_word_addr_t word_addr;
    cart_pkg::byte_t          hi;
    cart_pkg::byte_t          lo;
    errs_at_start = err_count;
    addrs[0] = 24'h019ABC;
    addrs[1] = 24'h8AF123;
    addrs[2] = 24'h3FFFFF;                          // Folds through the mask
    addrs[3] = 24'h408000;
    for (int i = 0; i < 4; i++) begin
      word_addr = lorom_word(addrs[i]);
      draw_random_byte(hi);
      draw_random_byte(lo);
      preload_word(word_addr[18:0], {hi, lo});
      snes_addr   = addrs[i];
      snes_read_n = 1'b0;
      step();
      compare_rom_addr("console_read rom_addr", word_addr, rom_addr);
      compare_byte("console_read data", addrs[i][0] ? lo : hi, snes_data_out);
      compare_bit("console_read oe", 1'b1, snes_data_oe);
    end
    snes_addr = 24'h001234;                         // Below the ROM window
    step();
    compare_bit("console_read low half oe", 1'b0, snes_data_oe);
    snes_addr = 24'h7E9000;                         // Work RAM bank
    step();
    compare_bit("console_read wram oe", 1'b0, snes_data_oe);
    snes_addr   = 24'h019ABC;                       // ROM window, no read strobe
    snes_read_n = 1'b1;
    step();
    compare_bit("console_read idle oe", 1'b0, snes_data_oe);
    report_test("console_read", errs_at_start);
  endtask

  task automatic test_alive_access();
    int              errs_at_start;
    cart_pkg::byte_t wdata;
    cart_pkg::byte_t rdata;
    errs_at_start = err_count;
    snes_addr = 24'h000100;
    cpu_run   = 1'b1;
    repeat (24) step();                             // Two CPU cycles to wake up
    draw_random_byte(wdata);
    mcu_access("alive_access write", 1'b1, 24'h002345, wdata, rdata);
    mcu_access("alive_access read", 1'b0, 24'h002345, 8'h00, rdata);
    compare_byte("alive_access", wdata, rdata);
    report_test("alive_access", errs_at_start);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Sequence

  initial begin
    int n;
    snes_addr    = '0;
    snes_read_n  = 1'b1;
    snes_write_n = 1'b1;
    mcu_req      = 1'b0;
    mcu_write    = 1'b0;
    mcu_addr     = '0;
    mcu_wdata    = '0;
    pl_en        = 1'b0;
    pl_idx       = '0;
    pl_word      = '0;
    cpu_run      = 1'b0;
    lfsr_state   = 16'd71;
    err_count    = 0;
    test_count   = 0;
    failed_tests = 0;

    n = 0;
    while (reset !== 1'b0 && n < 40) begin
      step();
      n = n + 1;
    end
    if (reset !== 1'b0) begin
      $display("reset was never released by the clock generator");
      err_count = err_count + 1;
    end
    step();

    test_reset_state();
    test_dead_writes();
    test_mcu_readback();
    test_console_read();
    test_alive_access();

    $display("tests %0d, failed tests %0d, errors %0d", test_count, failed_tests, err_count);
    if (err_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
rtl/cart_pkg.sv
rtl/snes_bus_sampler.sv
rtl/rom_slot_arbiter.sv
rtl/lorom_mapper.sv
rtl/rom_bus_mux.sv
rtl/cart_main.sv
bench/clock_gen.sv
bench/cart_main_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the cart_main testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --top-module cart_main_tb -f src.f -o cart_sim

./obj_dir/cart_sim | tee sim.log

if grep -qx "test passed" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi
